// ==== sim/bridgeTb.sv ====
// directed AHB-Lite master tests; Hreadyin follows Hreadyout, one sequence holds at most 32 beats
`timescale 1ns/1ps
`default_nettype none

module bridgeTb
	import ahbPkg::*, apbPkg::*;
();

	localparam int resetCycles = 5;
	localparam int qDepth = 32;
	localparam int rf0Words = 16;
	localparam int rf1Words = 8;
	// rough cycle budget of each test with margin
	localparam int budgetReset = 2 * resetCycles + 4;
	localparam int budgetIdle = 80;
	localparam int budgetSingle = 120;
	localparam int budgetPipe = 60;
	localparam int budgetUnmapped = 40;
	localparam int budgetOneShot = 120;
	localparam int budgetReload = 80;
	localparam int cycleLimit = budgetReset + budgetIdle + budgetSingle + budgetPipe
		+ budgetUnmapped + budgetOneShot + budgetReload;
	localparam ahbAddrT unmappedBase = 32'h8C00_0000;

	logic Hclk;
	logic Hresetn;
	ahbAddrT Haddr;
	htransT Htrans;
	logic Hwrite;
	ahbDataT Hwdata;
	logic Hreadyin;
	ahbDataT Hrdata;
	logic Hreadyout;
	logic timerIrq;

	logic [31:0] lfsrState;
	int errors;
	int checks;
	int cycleCount;

	// one pipelined sequence of transfers
	ahbAddrT qAddr [qDepth];
	logic qWrite [qDepth];
	ahbDataT qWdata [qDepth];
	ahbDataT qExpect [qDepth];
	ahbDataT qRdata [qDepth];
	int qLen;

	// expected register file contents
	ahbDataT model0 [rf0Words];
	ahbDataT model1 [rf1Words];

	bridgeTop #(.regFile0Words(rf0Words), .regFile1Words(rf1Words), .timerWidth(16)) u_bridgeTop
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Haddr     (Haddr),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hwdata    (Hwdata),
		.Hreadyin  (Hreadyin),
		.Hrdata    (Hrdata),
		.Hreadyout (Hreadyout),
		.timerIrq  (timerIrq)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #2 Hclk = ~Hclk;
	end

	// single slave, so the ready input mirrors its own output
	always @(posedge Hclk)
	begin
		#1;
		Hreadyin = Hreadyout;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge Hclk);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Something failed");
		$finish;
	end

	// fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] randomBits(input int nBits);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < nBits; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// word index wraps at the file depth
	function automatic ahbDataT modelRead(input ahbAddrT addr);
		ahbDataT value;
		value = '0;
		if (addr[31:26] == regFileBase[31:26])
			value = model0[(addr >> 2) % rf0Words];
		else if (addr[31:26] == regFile1Base[31:26])
			value = model1[(addr >> 2) % rf1Words];
		return value;
	endfunction

	task automatic modelWrite(input ahbAddrT addr, input ahbDataT data);
		if (addr[31:26] == regFileBase[31:26])
			model0[(addr >> 2) % rf0Words] = data;
		else if (addr[31:26] == regFile1Base[31:26])
			model1[(addr >> 2) % rf1Words] = data;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic nextCycle();
		@(posedge Hclk);
		#1;
	endtask

	task automatic clearQueue();
		qLen = 0;
	endtask

	task automatic pushWrite(input ahbAddrT addr, input ahbDataT data);
		qAddr[qLen] = addr;
		qWrite[qLen] = 1'b1;
		qWdata[qLen] = data;
		qExpect[qLen] = '0;
		qLen++;
		modelWrite(addr, data);
	endtask

	task automatic pushRead(input ahbAddrT addr, input ahbDataT expected);
		qAddr[qLen] = addr;
		qWrite[qLen] = 1'b0;
		qWdata[qLen] = '0;
		qExpect[qLen] = expected;
		qLen++;
	endtask

	task automatic driveAddr(input int i);
		Haddr = qAddr[i];
		Hwrite = qWrite[i];
		Htrans = htNonseq;
		// incrementing beat in the same direction
		if (i > 0 && qAddr[i] == qAddr[i-1] + 4 && qWrite[i] == qWrite[i-1])
			Htrans = htSeq;
	endtask

	// address and data phases overlap, each phase holds while Hreadyout is low
	task automatic runQueue();
		int aIdx;
		int dIdx;
		logic ready;
		aIdx = 0;
		dIdx = -1;
		driveAddr(0);
		while (aIdx < qLen || dIdx >= 0)
		begin
			@(negedge Hclk);
			ready = Hreadyout;
			if (ready && dIdx >= 0 && !qWrite[dIdx])
				qRdata[dIdx] = Hrdata;
			nextCycle();
			if (ready)
			begin
				dIdx = -1;
				if (aIdx < qLen)
				begin
					dIdx = aIdx;
					aIdx++;
					if (qWrite[dIdx])
						Hwdata = qWdata[dIdx];
				end
				if (aIdx < qLen)
					driveAddr(aIdx);
				else
					Htrans = htIdle;
			end
		end
	endtask

	task automatic checkReads(input string label);
		for (int i = 0; i < qLen; i++)
		begin
			if (!qWrite[i])
				checkValue($sformatf("Hrdata (%s, beat %0d)", label, i), qRdata[i], qExpect[i]);
		end
	endtask

	task automatic testResetState();
		@(negedge Hclk);
		checkValue("Hreadyout", Hreadyout, 32'h1);
		checkValue("timerIrq", timerIrq, 32'h0);
		nextCycle();
		clearQueue();
		for (int i = 0; i < rf0Words; i++)
			pushRead(regFileBase + 4 * i, 32'h0);
		for (int i = 0; i < rf1Words; i++)
			pushRead(regFile1Base + 4 * i, 32'h0);
		runQueue();
		checkReads("after reset");
	endtask

	task automatic testWriteRead();
		ahbAddrT addr;
		ahbDataT data;
		for (int k = 0; k < 6; k++)
		begin
			clearQueue();
			addr = ((k % 2) ? regFile1Base : regFileBase) + (randomBits(24) << 2);
			data = randomBits(32);
			pushWrite(addr, data);
			pushRead(addr, modelRead(addr));
			runQueue();
			checkReads("write then read");
		end
		// words 8 to 11 of the second file land on words 0 to 3
		for (int k = 0; k < 4; k++)
		begin
			clearQueue();
			data = randomBits(32);
			pushWrite(regFile1Base + 4 * (rf1Words + k), data);
			pushRead(regFile1Base + 4 * k, data);
			runQueue();
			checkReads("alias");
		end
	endtask

	task automatic testPipelined();
		ahbAddrT base;
		base = regFileBase + (randomBits(2) << 4);
		clearQueue();
		for (int k = 0; k < 4; k++)
			pushWrite(base + 4 * k, randomBits(32));
		for (int k = 0; k < 4; k++)
			pushRead(base + 4 * k, modelRead(base + 4 * k));
		runQueue();
		checkReads("pipelined");
	endtask

	task automatic testUnmapped();
		ahbDataT data;
		data = randomBits(32);
		clearQueue();
		pushWrite(unmappedBase + 32'h4, data);
		pushRead(unmappedBase + 32'h4, 32'h0);
		pushWrite(32'h0000_0004, ~data);
		pushRead(32'h0000_0004, 32'h0);
		pushRead(regFileBase + 32'h4, modelRead(regFileBase + 32'h4));
		pushRead(regFile1Base + 32'h4, modelRead(regFile1Base + 32'h4));
		runQueue();
		checkReads("unmapped");
	endtask

	task automatic testOneShot();
		int waited;
		clearQueue();
		pushWrite(timerBase, 32'd20);
		pushWrite(timerBase + 32'h4, 32'h5);
		runQueue();
		waited = 0;
		@(negedge Hclk);
		while (timerIrq !== 1'b1 && waited < 40)
		begin
			@(negedge Hclk);
			waited++;
		end
		checks++;
		assert (timerIrq === 1'b1)
		else
		begin
			errors++;
			$display("timerIrq did not rise within 40 cycles of enabling the one-shot timer");
		end
		nextCycle();
		clearQueue();
		pushRead(timerBase + 32'hC, 32'h1);
		pushWrite(timerBase + 32'hC, 32'h1);
		pushRead(timerBase + 32'hC, 32'h0);
		pushRead(timerBase + 32'h8, 32'h0);
		// enable drops at expiry, irq enable stays
		pushRead(timerBase + 32'h4, 32'h4);
		runQueue();
		checkReads("one-shot");
		@(negedge Hclk);
		checkValue("timerIrq", timerIrq, 32'h0);
		repeat (8) nextCycle();
		clearQueue();
		pushRead(timerBase + 32'h8, 32'h0);
		runQueue();
		checkReads("one-shot idle count");
	endtask

	task automatic testAutoReload();
		clearQueue();
		pushWrite(timerBase, 32'd10);
		pushWrite(timerBase + 32'h4, 32'h3);
		runQueue();
		repeat (15) nextCycle();
		clearQueue();
		pushRead(timerBase + 32'hC, 32'h1);
		pushRead(timerBase + 32'h8, 32'h0);
		runQueue();
		checkValue("timer status", qRdata[0], 32'h1);
		checks++;
		assert (qRdata[1] != 0 && qRdata[1] <= 10)
		else
		begin
			errors++;
			$display("FAIL t=%0t timer count: got %h, expected 1 to a", $time, qRdata[1]);
		end
		checkValue("timerIrq", timerIrq, 32'h0);
	endtask

	initial
	begin
		Hresetn = 1'b0;
		Haddr = '0;
		Htrans = htIdle;
		Hwrite = 1'b0;
		Hwdata = '0;
		Hreadyin = 1'b0;
		lfsrState = 32'h49913d45;
		errors = 0;
		checks = 0;
		qLen = 0;
		for (int i = 0; i < rf0Words; i++)
			model0[i] = '0;
		for (int i = 0; i < rf1Words; i++)
			model1[i] = '0;
		repeat (resetCycles) @(posedge Hclk);
		#1;
		Hresetn = 1'b1;
		nextCycle();
		testResetState();
		testWriteRead();
		testPipelined();
		testUnmapped();
		testOneShot();
		testAutoReload();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/ahbPkg.sv
src/apbPkg.sv
src/ahbSlaveInterface.sv
src/apbFsmController.sv
src/apbRegFile.sv
src/apbTimer.sv
src/bridgeTop.sv
sim/bridgeTb.sv

// ==== src/ahbPkg.sv ====
// AHB-Lite side types for 32-bit word transfers only; no size, burst, protection or response
`default_nettype none

package ahbPkg;

	// byte address, the same width on the AHB and APB sides
	typedef logic [31:0] ahbAddrT;

	// data word in either direction
	typedef logic [31:0] ahbDataT;

	typedef enum logic [1:0]
	{
		htIdle   = 2'b00,
		htBusy   = 2'b01,
		htNonseq = 2'b10,
		htSeq    = 2'b11
	} htransT;

	// one accepted address phase
	// sel is one-hot in the same bit order as apbPkg pselT
	typedef struct packed
	{
		ahbAddrT    addr;
		logic       write;
		logic [2:0] sel;
	} ahbPipeT;

endpackage

`default_nettype wire

// ==== src/ahbSlaveInterface.sv ====
// single-slave AHB-Lite port: Hreadyin must follow Hreadyout; current stage is the live phase
`timescale 1ns/1ps
`default_nettype none

module ahbSlaveInterface
	import ahbPkg::*, apbPkg::*;
(
	input  logic    Hclk,
	input  logic    Hresetn,
	input  ahbAddrT Haddr,
	input  htransT  Htrans,
	input  logic    Hwrite,
	input  ahbDataT Hwdata,
	input  logic    Hreadyin,
	input  ahbDataT prdata0,
	input  ahbDataT prdata1,
	input  ahbDataT prdata2,
	input  pselT    Pselx,
	output logic    valid,
	output ahbPipeT pipeCur,
	output ahbPipeT pipePrev,
	output ahbDataT wdataCur,
	output ahbDataT wdataPrev,
	output ahbDataT Hrdata
);

	pselT selDecode;
	logic active;
	logic wrDataPhase;

	always_comb
	begin
		selDecode = '0;
		if (Haddr[31:regionLsb] == regFileBase[31:regionLsb])
			selDecode = selRegFile0;
		else if (Haddr[31:regionLsb] == regFile1Base[31:regionLsb])
			selDecode = selRegFile1;
		else if (Haddr[31:regionLsb] == timerBase[31:regionLsb])
			selDecode = selTimer;
	end

	// idle and busy phases are never accepted
	assign active = Hreadyin && (Htrans == htNonseq || Htrans == htSeq);
	assign valid = active && (selDecode != '0);

	assign pipeCur = '{addr: Haddr, write: Hwrite, sel: selDecode};
	assign wdataCur = Hwdata;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			pipePrev <= '0;
			wrDataPhase <= 1'b0;
		end
		else
		begin
			if (valid)
				pipePrev <= pipeCur;
			wrDataPhase <= valid && Hwrite;
		end
	end

	// write data arrives the cycle after its address
	always_ff @(posedge Hclk)
	begin
		if (wrDataPhase)
			wdataPrev <= Hwdata;
	end

	always_comb
	begin
		case (Pselx)
			selRegFile0: Hrdata = prdata0;
			selRegFile1: Hrdata = prdata1;
			selTimer:    Hrdata = prdata2;
			default:     Hrdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/apbFsmController.sv ====
// APB2 master FSM with registered outputs; assumes Hreadyin follows Hreadyout
`timescale 1ns/1ps
`default_nettype none

module apbFsmController
	import ahbPkg::*, apbPkg::*;
(
	input  logic    Hclk,
	input  logic    Hresetn,
	input  logic    valid,
	input  ahbPipeT pipeCur,
	input  ahbPipeT pipePrev,
	input  ahbDataT wdataCur,
	input  ahbDataT wdataPrev,
	output apbReqT  apbReq,
	output logic    Hreadyout
);

	apbStateT state;
	apbStateT stateNext;
	apbReqT reqNext;
	logic readyNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= stIdle;
			apbReq <= '0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			apbReq <= reqNext;
			Hreadyout <= readyNext;
		end
	end

	// outputs hold unless a transition changes them
	always_comb
	begin
		stateNext = state;
		reqNext = apbReq;
		readyNext = Hreadyout;
		case (state)
			// the bus is free in these states, so look at the live phase
			stIdle, stReadEnable, stWriteEnable:
			begin
				reqNext.Pselx = '0;
				reqNext.Penable = 1'b0;
				readyNext = 1'b1;
				stateNext = stIdle;
				if (valid && !pipeCur.write)
				begin
					reqNext.Paddr = pipeCur.addr;
					reqNext.Pwrite = 1'b0;
					reqNext.Pselx = pipeCur.sel;
					readyNext = 1'b0;
					stateNext = stRead;
				end
				else if (valid)
				begin
					stateNext = stWriteWait;
				end
			end

			// data of the accepted write is on Hwdata now
			stWriteWait:
			begin
				reqNext.Paddr = pipePrev.addr;
				reqNext.Pwdata = wdataCur;
				reqNext.Pwrite = 1'b1;
				reqNext.Pselx = pipePrev.sel;
				reqNext.Penable = 1'b0;
				readyNext = 1'b0;
				stateNext = valid ? stWritePipe : stWrite;
			end

			stRead:
			begin
				reqNext.Penable = 1'b1;
				readyNext = 1'b1;
				stateNext = stReadEnable;
			end

			stWrite:
			begin
				reqNext.Penable = 1'b1;
				readyNext = 1'b1;
				stateNext = stWriteEnable;
			end

			// a pending read must not see its data phase end early
			stWritePipe:
			begin
				reqNext.Penable = 1'b1;
				readyNext = pipePrev.write;
				stateNext = stWriteEnablePipe;
			end

			stWriteEnablePipe:
			begin
				reqNext.Paddr = pipePrev.addr;
				reqNext.Pselx = pipePrev.sel;
				reqNext.Penable = 1'b0;
				readyNext = 1'b0;
				if (pipePrev.write)
				begin
					reqNext.Pwdata = wdataPrev;
					reqNext.Pwrite = 1'b1;
					stateNext = valid ? stWritePipe : stWrite;
				end
				else
				begin
					reqNext.Pwrite = 1'b0;
					stateNext = stRead;
				end
			end

			default:
			begin
				reqNext = '0;
				readyNext = 1'b1;
				stateNext = stIdle;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/apbPkg.sv ====
// APB2 request bus, controller states and map of three 64 MiB regions; no PREADY or PSLVERR
`default_nettype none

package apbPkg;

	import ahbPkg::*;

	// one-hot peripheral select
	typedef logic [2:0] pselT;

	localparam pselT selRegFile0 = 3'b001;
	localparam pselT selRegFile1 = 3'b010;
	localparam pselT selTimer    = 3'b100;

	// region bases, only bits above regionLsb are decoded
	localparam ahbAddrT regFileBase  = 32'h8000_0000;
	localparam ahbAddrT regFile1Base = 32'h8400_0000;
	localparam ahbAddrT timerBase    = 32'h8800_0000;
	localparam int regionLsb = 26;

	typedef struct packed
	{
		ahbAddrT Paddr;
		ahbDataT Pwdata;
		logic    Pwrite;
		pselT    Pselx;
		logic    Penable;
	} apbReqT;

	typedef enum logic [2:0]
	{
		stIdle            = 3'b000,
		stWriteWait       = 3'b001,
		stRead            = 3'b010,
		stWrite           = 3'b011,
		stWritePipe       = 3'b100,
		stReadEnable      = 3'b101,
		stWriteEnable     = 3'b110,
		stWriteEnablePipe = 3'b111
	} apbStateT;

endpackage

`default_nettype wire

// ==== src/apbRegFile.sv ====
// APB word register file; regWords must be a power of two, higher addresses alias
`timescale 1ns/1ps
`default_nettype none

module apbRegFile
	import ahbPkg::*, apbPkg::*;
#(
	parameter int regWords = 16
)
(
	input  logic    Hclk,
	input  logic    Hresetn,
	input  apbReqT  apbReq,
	input  logic    sel,
	output ahbDataT prdata
);

	localparam int idxBits = (regWords > 1) ? $clog2(regWords) : 1;

	typedef logic [idxBits-1:0] regIdxT;

	ahbDataT regs [regWords];
	regIdxT idx;

	// word number modulo depth
	assign idx = apbReq.Paddr[idxBits+1:2];

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < regWords; i++)
				regs[i] <= '0;
		end
		else if (sel && apbReq.Penable && apbReq.Pwrite)
		begin
			regs[idx] <= apbReq.Pwdata;
		end
	end

	assign prdata = sel ? regs[idx] : '0;

endmodule

`default_nettype wire

// ==== src/apbTimer.sv ====
// APB down-counter; timerWidth up to 32, an APB write wins over the count on the same edge
`timescale 1ns/1ps
`default_nettype none

module apbTimer
	import ahbPkg::*, apbPkg::*;
#(
	parameter int timerWidth = 16
)
(
	input  logic    Hclk,
	input  logic    Hresetn,
	input  apbReqT  apbReq,
	input  logic    sel,
	output ahbDataT prdata,
	output logic    timerIrq
);

	localparam logic [1:0] offLoad   = 2'd0;
	localparam logic [1:0] offCtrl   = 2'd1;
	localparam logic [1:0] offCount  = 2'd2;
	localparam logic [1:0] offStatus = 2'd3;

	typedef logic [timerWidth-1:0] countT;

	countT loadVal;
	countT count;
	logic enable;
	logic autoReload;
	logic irqEnable;
	logic expired;
	logic wrEn;
	logic expire;
	logic [1:0] offset;

	assign offset = apbReq.Paddr[3:2];
	assign wrEn = sel && apbReq.Penable && apbReq.Pwrite;
	// last decrement reaches zero on this edge
	assign expire = enable && (count <= countT'(1));

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			loadVal <= '0;
			count <= '0;
			enable <= 1'b0;
			autoReload <= 1'b0;
			irqEnable <= 1'b0;
			expired <= 1'b0;
		end
		else
		begin
			if (expire)
			begin
				count <= autoReload ? loadVal : '0;
				enable <= autoReload;
			end
			else if (enable)
			begin
				count <= count - 1'b1;
			end
			if (wrEn && offset == offLoad)
			begin
				loadVal <= apbReq.Pwdata[timerWidth-1:0];
				count <= apbReq.Pwdata[timerWidth-1:0];
			end
			if (wrEn && offset == offCtrl)
			begin
				enable <= apbReq.Pwdata[0];
				autoReload <= apbReq.Pwdata[1];
				irqEnable <= apbReq.Pwdata[2];
			end
			// set beats write-1-to-clear
			if (expire)
				expired <= 1'b1;
			else if (wrEn && offset == offStatus && apbReq.Pwdata[0])
				expired <= 1'b0;
		end
	end

	always_comb
	begin
		prdata = '0;
		if (sel)
		begin
			case (offset)
				offLoad:   prdata = ahbDataT'(loadVal);
				offCtrl:   prdata = {29'b0, irqEnable, autoReload, enable};
				offCount:  prdata = ahbDataT'(count);
				offStatus: prdata = {31'b0, expired};
			endcase
		end
	end

	assign timerIrq = expired && irqEnable;

endmodule

`default_nettype wire

// ==== src/bridgeTop.sv ====
// AHB-Lite to APB2 bridge with two register files and a timer; Hreadyin must follow Hreadyout
`timescale 1ns/1ps
`default_nettype none

module bridgeTop
	import ahbPkg::*, apbPkg::*;
#(
	parameter int regFile0Words = 16,
	parameter int regFile1Words = 8,
	parameter int timerWidth = 16
)
(
	input  logic    Hclk,
	input  logic    Hresetn,
	input  ahbAddrT Haddr,
	input  htransT  Htrans,
	input  logic    Hwrite,
	input  ahbDataT Hwdata,
	input  logic    Hreadyin,
	output ahbDataT Hrdata,
	output logic    Hreadyout,
	output logic    timerIrq
);

	logic valid;
	ahbPipeT pipeCur;
	ahbPipeT pipePrev;
	ahbDataT wdataCur;
	ahbDataT wdataPrev;
	apbReqT apbReq;
	ahbDataT prdata0;
	ahbDataT prdata1;
	ahbDataT prdata2;

	ahbSlaveInterface u_ahbSlaveInterface
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Haddr     (Haddr),
		.Htrans    (Htrans),
		.Hwrite    (Hwrite),
		.Hwdata    (Hwdata),
		.Hreadyin  (Hreadyin),
		.prdata0   (prdata0),
		.prdata1   (prdata1),
		.prdata2   (prdata2),
		.Pselx     (apbReq.Pselx),
		.valid     (valid),
		.pipeCur   (pipeCur),
		.pipePrev  (pipePrev),
		.wdataCur  (wdataCur),
		.wdataPrev (wdataPrev),
		.Hrdata    (Hrdata)
	);

	apbFsmController u_apbFsmController
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.pipeCur   (pipeCur),
		.pipePrev  (pipePrev),
		.wdataCur  (wdataCur),
		.wdataPrev (wdataPrev),
		.apbReq    (apbReq),
		.Hreadyout (Hreadyout)
	);

	// select bit order follows apbPkg selRegFile0, selRegFile1, selTimer
	apbRegFile #(.regWords(regFile0Words)) u_regFile0
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn),
		.apbReq  (apbReq),
		.sel     (apbReq.Pselx[0]),
		.prdata  (prdata0)
	);

	apbRegFile #(.regWords(regFile1Words)) u_regFile1
	(
		.Hclk    (Hclk),
		.Hresetn (Hresetn),
		.apbReq  (apbReq),
		.sel     (apbReq.Pselx[1]),
		.prdata  (prdata1)
	);

	apbTimer #(.timerWidth(timerWidth)) u_timer
	(
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.apbReq   (apbReq),
		.sel      (apbReq.Pselx[2]),
		.prdata   (prdata2),
		.timerIrq (timerIrq)
	);

endmodule

`default_nettype wire
